// ==== source/mam_pkg.sv ====
// Shared widths, vector typedefs, bus and command structs and FSM state enums
package mam_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Word address and data width of the memory bus
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] word_addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Burst length encoded as word count minus one, so 0 means one word
  typedef logic [3:0] burst_len_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and command payloads
  ////////////////////////////////////////////////////////////////////////////

  // Request payload of one bus cycle, 50 bits
  typedef struct packed {
    word_addr_t addr;
    data_t      wdata;
    logic       we;
    logic       lock;
  } bus_req_t;

  // Response of one bus cycle, 33 bits
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Debug command, wdata is the fill value of a write burst, 53 bits
  typedef struct packed {
    word_addr_t addr;
    burst_len_t len;
    logic       we;
    data_t      wdata;
  } mam_cmd_t;

  // Arbiter ownership states
  typedef enum logic [1:0] {ARB_IDLE, ARB_MAM, ARB_CPU} arb_state_e;

  // Command engine states
  typedef enum logic [2:0] {
    ENG_IDLE, ENG_LOCK, ENG_REQ, ENG_WAIT_ACK, ENG_RELEASE, ENG_DONE
  } eng_state_e;

endpackage

// ==== source/mam_cmd_engine.sv ====
// Debug command engine issuing locked word bursts and collecting read data
`timescale 1ns/1ps

module mam_cmd_engine import mam_pkg::*; (
  input  logic       apb4_in_clk_i,
  input  logic       rst_n_i,
  // Debug host command handshake
  input  logic       cmd_req_i,
  input  mam_cmd_t   cmd_i,
  output logic       cmd_ack_o,
  output logic       cmd_err_o,
  // Bus master side toward the arbiter
  output logic       bus_req_o,
  output bus_req_t   bus_o,
  input  logic       bus_ack_i,
  input  bus_rsp_t   bus_rsp_i,
  // Read data toward the FIFO
  input  logic       fifo_full_i,
  output logic       push_o,
  output data_t      push_data_o
);

  eng_state_e state;
  logic       lock_q;
  logic       req_q;
  logic       ack_q;
  logic       err_q;

  // Burst payload, loaded at command start
  word_addr_t cur_addr;
  burst_len_t remaining;
  data_t      wdata_q;
  logic       we_q;

  logic cmd_start;
  logic can_issue;
  logic word_ok;
  logic word_err;

  // New command accepted from idle
  assign cmd_start = (state == ENG_IDLE) && cmd_req_i;
  // Previous ack gone, and a read needs room in the FIFO
  assign can_issue = (state == ENG_REQ) && !bus_ack_i && (we_q || !fifo_full_i);
  // Ack of the current word, split by response status
  assign word_ok   = (state == ENG_WAIT_ACK) && bus_ack_i && !bus_rsp_i.err;
  assign word_err  = (state == ENG_WAIT_ACK) && bus_ack_i && bus_rsp_i.err;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge apb4_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state  <= ENG_IDLE;
      lock_q <= 1'b0;
      req_q  <= 1'b0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      unique case (state)
        ENG_IDLE: begin
          // Lock goes up first, req follows after one cycle
          if (cmd_start) begin
            lock_q <= 1'b1;
            state  <= ENG_LOCK;
          end
        end
        ENG_LOCK: state <= ENG_REQ;
        ENG_REQ: begin
          // Stalls here with lock held on a full FIFO
          if (can_issue) begin
            req_q <= 1'b1;
            state <= ENG_WAIT_ACK;
          end
        end
        ENG_WAIT_ACK: begin
          if (bus_ack_i) begin
            req_q <= 1'b0;
            if (word_err) begin
              err_q <= 1'b1;
              state <= ENG_RELEASE;
            end else if (remaining == '0) begin
              state <= ENG_RELEASE;
            end else begin
              state <= ENG_REQ;
            end
          end
        end
        ENG_RELEASE: begin
          // Lock drops only once the last ack is low
          if (!bus_ack_i) begin
            lock_q <= 1'b0;
            state  <= ENG_DONE;
          end
        end
        ENG_DONE: begin
          if (!ack_q) begin
            ack_q <= 1'b1;
          end else if (!cmd_req_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            state <= ENG_IDLE;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

  // Burst address and word count
  always_ff @(posedge apb4_in_clk_i) begin
    if (cmd_start) begin
      cur_addr  <= cmd_i.addr;
      remaining <= cmd_i.len;
      wdata_q   <= cmd_i.wdata;
      we_q      <= cmd_i.we;
    end else if (word_ok && remaining != '0) begin
      cur_addr  <= cur_addr + 1'b1;
      remaining <= remaining - 1'b1;
    end
  end

  assign cmd_ack_o   = ack_q;
  assign cmd_err_o   = err_q;
  assign bus_req_o   = req_q;
  assign bus_o       = '{addr: cur_addr, wdata: wdata_q, we: we_q, lock: lock_q};

  // Each good read word goes to the FIFO on its ack cycle
  assign push_o      = word_ok && !we_q;
  assign push_data_o = bus_rsp_i.rdata;

endmodule

// ==== source/mam_bus_arbiter.sv ====
// Lock-based arbiter and request/response multiplexer for debug engine and CPU
`timescale 1ns/1ps

module mam_bus_arbiter import mam_pkg::*; (
  input  logic     apb4_in_clk_i,
  input  logic     rst_n_i,
  // Debug engine master
  input  logic     mam_req_i,
  input  bus_req_t mam_bus_i,
  output logic     mam_ack_o,
  output bus_rsp_t mam_rsp_o,
  // CPU master
  input  logic     cpu_req_i,
  input  bus_req_t cpu_bus_i,
  output logic     cpu_ack_o,
  output bus_rsp_t cpu_rsp_o,
  // Memory target
  output logic     mem_req_o,
  output bus_req_t mem_bus_o,
  input  logic     mem_ack_i,
  input  bus_rsp_t mem_rsp_i
);

  arb_state_e state;
  arb_state_e state_next;

  logic grant_mam;
  logic grant_cpu;

  ////////////////////////////////////////////////////////////////////////////
  // Ownership FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge apb4_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= ARB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Debug side wins from idle; an owner stays while its lock is high
  always_comb begin
    state_next = ARB_IDLE;
    unique case (state)
      ARB_IDLE: begin
        if (mam_bus_i.lock) begin
          state_next = ARB_MAM;
        end else if (cpu_bus_i.lock) begin
          state_next = ARB_CPU;
        end
      end
      ARB_MAM: begin
        if (mam_bus_i.lock) begin
          state_next = ARB_MAM;
        end
      end
      ARB_CPU: begin
        // Waiting debug lock takes over without passing through idle
        if (cpu_bus_i.lock) begin
          state_next = ARB_CPU;
        end else if (mam_bus_i.lock) begin
          state_next = ARB_MAM;
        end
      end
      default: state_next = ARB_IDLE;
    endcase
  end

  // Grant decoded from the state register
  assign grant_mam = (state == ARB_MAM);
  assign grant_cpu = (state == ARB_CPU);

  ////////////////////////////////////////////////////////////////////////////
  // Request path toward memory
  ////////////////////////////////////////////////////////////////////////////

  // Ungranted master is held off, nothing reaches memory from idle
  assign mem_req_o = (grant_mam && mam_req_i) || (grant_cpu && cpu_req_i);
  assign mem_bus_o = grant_cpu ? cpu_bus_i : (grant_mam ? mam_bus_i : '0);

  ////////////////////////////////////////////////////////////////////////////
  // Response path back to the masters
  ////////////////////////////////////////////////////////////////////////////

  assign mam_ack_o = grant_mam && mem_ack_i;
  assign mam_rsp_o = grant_mam ? mem_rsp_i : '0;

  assign cpu_ack_o = grant_cpu && mem_ack_i;
  assign cpu_rsp_o = grant_cpu ? mem_rsp_i : '0;

endmodule

// ==== source/mam_rdata_fifo.sv ====
// Show-ahead circular FIFO holding burst read data for the debug host
`timescale 1ns/1ps

module mam_rdata_fifo import mam_pkg::*; #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic  apb4_in_clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  data_t push_data_i,
  input  logic  pop_i,
  output logic  full_o,
  output logic  valid_o,
  output data_t data_o
);

  // Index width, pointers carry one extra wrap bit
  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  data_t       mem [FIFO_DEPTH];
  logic [AW:0] wptr;
  logic [AW:0] rptr;
  logic        empty;
  logic        do_push;
  logic        do_pop;

  // Same index with different wrap bit means full
  assign empty   = (wptr == rptr);
  assign full_o  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

  // Push on full and pop on empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty;

  always_ff @(posedge apb4_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (do_push) begin
        wptr <= wptr + 1'b1;
      end
      if (do_pop) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  always_ff @(posedge apb4_in_clk_i) begin
    if (do_push) begin
      mem[wptr[AW-1:0]] <= push_data_i;
    end
  end

  // Head word visible as soon as it is stored
  assign valid_o = !empty;
  assign data_o  = mem[rptr[AW-1:0]];

endmodule

// ==== source/mam_sram_target.sv ====
// Word SRAM target with registered four-phase acknowledge and range error
`timescale 1ns/1ps

module mam_sram_target import mam_pkg::*; #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic     apb4_in_clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  bus_req_t bus_i,
  output logic     ack_o,
  output bus_rsp_t rsp_o
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  data_t             mem [MEM_WORDS];
  logic              ack_q;
  bus_rsp_t          rsp_q;
  logic              in_range;
  logic              ack_rise;
  logic [IDX_W-1:0]  idx;

  // Addresses at or above the memory size are flagged
  assign in_range = (int'(bus_i.addr) < MEM_WORDS);
  assign idx      = bus_i.addr[IDX_W-1:0];

  // First edge that samples req high with ack still low
  assign ack_rise = req_i && !ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Ack follows req with one edge of delay in both directions
  always_ff @(posedge apb4_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage and response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge apb4_in_clk_i) begin
    if (ack_rise) begin
      // Write lands at the ack edge, never out of range
      if (bus_i.we && in_range) begin
        mem[idx] <= bus_i.wdata;
      end
      rsp_q.rdata <= in_range ? mem[idx] : '0;
      rsp_q.err   <= !in_range;
    end
  end

  assign ack_o = ack_q;
  assign rsp_o = rsp_q;

endmodule

// ==== source/mam_subsystem_top.sv ====
// Memory access subsystem top with engine, FIFO, arbiter and SRAM instances
`timescale 1ns/1ps

module mam_subsystem_top import mam_pkg::*; #(
  parameter int unsigned MEM_WORDS  = 256,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic     apb4_in_clk_i,
  input  logic     rst_n_i,
  // CPU port
  input  logic     cpu_req_i,
  input  bus_req_t cpu_bus_i,
  output logic     cpu_ack_o,
  output bus_rsp_t cpu_rsp_o,
  // Debug host command port
  input  logic     dbg_cmd_req_i,
  input  mam_cmd_t dbg_cmd_i,
  output logic     dbg_cmd_ack_o,
  output logic     dbg_cmd_err_o,
  // Debug read data
  input  logic     rd_pop_i,
  output logic     rd_valid_o,
  output data_t    rd_data_o
);

  // Engine to arbiter
  logic     mam_req;
  bus_req_t mam_bus;
  logic     mam_ack;
  bus_rsp_t mam_rsp;

  // Arbiter to memory
  logic     mem_req;
  bus_req_t mem_bus;
  logic     mem_ack;
  bus_rsp_t mem_rsp;

  // Engine to FIFO
  logic     push;
  data_t    push_data;
  logic     fifo_full;

  mam_cmd_engine i_mam_cmd_engine (
    .apb4_in_clk_i (apb4_in_clk_i), .rst_n_i     (rst_n_i),
    .cmd_req_i     (dbg_cmd_req_i), .cmd_i       (dbg_cmd_i),
    .cmd_ack_o     (dbg_cmd_ack_o), .cmd_err_o   (dbg_cmd_err_o),
    .bus_req_o     (mam_req),       .bus_o       (mam_bus),
    .bus_ack_i     (mam_ack),       .bus_rsp_i   (mam_rsp),
    .fifo_full_i   (fifo_full),     .push_o      (push),
    .push_data_o   (push_data)
  );

  mam_rdata_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_mam_rdata_fifo (
    .apb4_in_clk_i (apb4_in_clk_i), .rst_n_i (rst_n_i),
    .push_i (push), .push_data_i (push_data), .pop_i (rd_pop_i),
    .full_o (fifo_full), .valid_o (rd_valid_o), .data_o (rd_data_o)
  );

  mam_bus_arbiter i_mam_bus_arbiter (
    .apb4_in_clk_i (apb4_in_clk_i), .rst_n_i   (rst_n_i),
    .mam_req_i     (mam_req),       .mam_bus_i (mam_bus),
    .mam_ack_o     (mam_ack),       .mam_rsp_o (mam_rsp),
    .cpu_req_i     (cpu_req_i),     .cpu_bus_i (cpu_bus_i),
    .cpu_ack_o     (cpu_ack_o),     .cpu_rsp_o (cpu_rsp_o),
    .mem_req_o     (mem_req),       .mem_bus_o (mem_bus),
    .mem_ack_i     (mem_ack),       .mem_rsp_i (mem_rsp)
  );

  mam_sram_target #(.MEM_WORDS(MEM_WORDS)) i_mam_sram_target (
    .apb4_in_clk_i (apb4_in_clk_i), .rst_n_i (rst_n_i),
    .req_i (mem_req), .bus_i (mem_bus), .ack_o (mem_ack), .rsp_o (mem_rsp)
  );

endmodule

// ==== dv/mam_subsystem_properties.sv ====
// Arbiter protocol properties, bound into the bus arbiter
`timescale 1ns/1ps

module mam_subsystem_properties import mam_pkg::*; (
  input logic       apb4_in_clk_i,
  input logic       rst_n_i,
  input arb_state_e state_i,
  input bus_req_t   mam_bus_i,
  input bus_req_t   cpu_bus_i,
  input logic       mam_ack_i,
  input logic       cpu_ack_i,
  input logic       mem_req_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Grant and acknowledge
  ////////////////////////////////////////////////////////////////////////////

  // Only the owner of the bus sees ack
  a_mam_ack_granted: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    mam_ack_i |-> state_i == ARB_MAM) else $error("debug ack without grant");
  a_cpu_ack_granted: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    cpu_ack_i |-> state_i == ARB_CPU) else $error("CPU ack without grant");

  // Owner keeps the bus while it holds lock
  a_mam_keep: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    state_i == ARB_MAM && mam_bus_i.lock |=> state_i == ARB_MAM)
    else $error("debug grant lost under lock");
  a_cpu_keep: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    state_i == ARB_CPU && cpu_bus_i.lock |=> state_i == ARB_CPU)
    else $error("CPU grant lost under lock");

  a_mem_req_owner: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    mem_req_i |-> state_i != ARB_IDLE) else $error("memory request with no owner");

endmodule

bind mam_bus_arbiter mam_subsystem_properties i_mam_subsystem_properties (
  .apb4_in_clk_i (apb4_in_clk_i), .rst_n_i (rst_n_i), .state_i (state),
  .mam_bus_i (mam_bus_i), .cpu_bus_i (cpu_bus_i), .mam_ack_i (mam_ack_o),
  .cpu_ack_i (cpu_ack_o), .mem_req_i (mem_req_o)
);

// ==== dv/mam_subsystem_tb.sv ====
// Testbench top with clock, reset, LFSR, stimulus tasks, memory model, checks and watchdog
`timescale 1ns/1ps

module mam_subsystem_tb import mam_pkg::*;;

  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam time         PERIOD     = 40ns;
  // Rough count of bus accesses in all tests together
  localparam int unsigned N_PLANNED  = 250;

  logic     apb4_in_clk_i;
  logic     rst_n_i;
  logic     cpu_req_i;
  bus_req_t cpu_bus_i;
  logic     cpu_ack_o;
  bus_rsp_t cpu_rsp_o;
  logic     dbg_cmd_req_i;
  mam_cmd_t dbg_cmd_i;
  logic     dbg_cmd_ack_o;
  logic     dbg_cmd_err_o;
  logic     rd_pop_i;
  logic     rd_valid_o;
  data_t    rd_data_o;

  // Reference memory and which words hold a known value
  data_t          model [MEM_WORDS];
  logic [MEM_WORDS-1:0] known;
  logic [31:0]    lfsr;
  int unsigned    mismatches;
  word_addr_t     written_q [$];

  // Expected values, set by the stimulus before each access
  data_t exp_cpu_rdata;
  logic  exp_cpu_err;
  logic  chk_cpu_rdata;
  logic  exp_dbg_err;
  data_t exp_rd_data;
  logic  expect_empty;
  logic  dbg_pending;
  logic  cpu_seq_active;
  logic  stall_check;
  logic  drain_check;

  mam_subsystem_top #(.MEM_WORDS(MEM_WORDS), .FIFO_DEPTH(FIFO_DEPTH)) i_mam_subsystem_top (
    .apb4_in_clk_i (apb4_in_clk_i), .rst_n_i (rst_n_i),
    .cpu_req_i (cpu_req_i), .cpu_bus_i (cpu_bus_i),
    .cpu_ack_o (cpu_ack_o), .cpu_rsp_o (cpu_rsp_o),
    .dbg_cmd_req_i (dbg_cmd_req_i), .dbg_cmd_i (dbg_cmd_i),
    .dbg_cmd_ack_o (dbg_cmd_ack_o), .dbg_cmd_err_o (dbg_cmd_err_o),
    .rd_pop_i (rd_pop_i), .rd_valid_o (rd_valid_o), .rd_data_o (rd_data_o)
  );

  initial begin
    apb4_in_clk_i = 1'b0;
    forever #(PERIOD/2) apb4_in_clk_i = ~apb4_in_clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking assertions
  ////////////////////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge apb4_in_clk_i)
    !rst_n_i |-> !cpu_ack_o && !dbg_cmd_ack_o && !dbg_cmd_err_o && !rd_valid_o)
    else begin
      mismatches++;
      $display("Mismatch at %0t: outputs not low in reset", $time);
    end

  a_cpu_rsp: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    cpu_ack_o |-> cpu_rsp_o.err == exp_cpu_err &&
                  (!chk_cpu_rdata || cpu_rsp_o.rdata == exp_cpu_rdata))
    else begin
      mismatches++;
      $display("Mismatch at %0t: cpu rsp %h/%b, expected %h/%b", $time,
               cpu_rsp_o.rdata, cpu_rsp_o.err, exp_cpu_rdata, exp_cpu_err);
    end

  a_dbg_err: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    dbg_cmd_ack_o |-> dbg_cmd_err_o == exp_dbg_err)
    else begin
      mismatches++;
      $display("Mismatch at %0t: debug command err flag", $time);
    end

  a_rd_data: assert property (@(posedge apb4_in_clk_i) disable iff (!rst_n_i)
    rd_pop_i && rd_valid_o |-> rd_data_o == exp_rd_data)
    else begin
      mismatches++;
      $display("Mismatch at %0t: FIFO word %h, expected %h", $time, rd_data_o, exp_rd_data);
    end

  a_rd_empty: assert property (@(posedge apb4_in_clk_i) expect_empty |-> !rd_valid_o)
    else begin
      mismatches++;
      $display("Mismatch at %0t: FIFO holds extra words", $time);
    end

  // Debug side wins from idle, so the CPU waits for the command end
  a_dbg_first: assert property (@(posedge apb4_in_clk_i) dbg_pending |-> !cpu_ack_o)
    else begin
      mismatches++;
      $display("Mismatch at %0t: CPU acked before debug", $time);
    end

  a_cpu_first: assert property (@(posedge apb4_in_clk_i) cpu_seq_active |-> !rd_valid_o)
    else begin
      mismatches++;
      $display("Mismatch at %0t: debug data inside CPU lock", $time);
    end

  a_stall: assert property (@(posedge apb4_in_clk_i) stall_check |-> rd_valid_o && !dbg_cmd_ack_o)
    else begin
      mismatches++;
      $display("Mismatch at %0t: burst did not stall", $time);
    end

  // Command ends only after the host took the last word
  a_drain: assert property (@(posedge apb4_in_clk_i) drain_check |-> !dbg_cmd_ack_o)
    else begin
      mismatches++;
      $display("Mismatch at %0t: debug ack before the last pop", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic tick();
    @(posedge apb4_in_clk_i);
    #2;
  endtask

  task automatic cpu_lock(logic on);
    cpu_bus_i.lock = on;
    tick();
  endtask

  // One four-phase CPU cycle, lock handled by the caller
  task automatic cpu_xfer(int addr, logic we, data_t wdata);
    logic in_range;
    in_range      = addr < MEM_WORDS;
    exp_cpu_err   = !in_range;
    exp_cpu_rdata = in_range ? model[addr] : '0;
    chk_cpu_rdata = !in_range || (!we && known[addr]);
    cpu_bus_i.addr  = word_addr_t'(addr);
    cpu_bus_i.we    = we;
    cpu_bus_i.wdata = wdata;
    cpu_req_i = 1'b1;
    while (!cpu_ack_o) tick();
    cpu_req_i = 1'b0;
    while (cpu_ack_o) tick();
    if (we && in_range) begin
      model[addr] = wdata;
      known[addr] = 1'b1;
    end
  endtask

  task automatic cpu_access(int addr, logic we, data_t wdata);
    cpu_lock(1'b1);
    cpu_xfer(addr, we, wdata);
    cpu_lock(1'b0);
  endtask

  // Debug command, model follows fill words up to the first bad address
  task automatic dbg_command(int addr, int words, logic we, data_t wdata);
    exp_dbg_err = (addr + words) > MEM_WORDS;
    dbg_cmd_i = '{addr: word_addr_t'(addr), len: burst_len_t'(words - 1), we: we, wdata: wdata};
    dbg_cmd_req_i = 1'b1;
    while (!dbg_cmd_ack_o) tick();
    dbg_pending = 1'b0;
    dbg_cmd_req_i = 1'b0;
    while (dbg_cmd_ack_o) tick();
    for (int i = 0; we && i < words && addr + i < MEM_WORDS; i++) begin
      model[addr + i] = wdata;
      known[addr + i] = 1'b1;
    end
  endtask

  task automatic pop_words(int addr, int n);
    for (int i = 0; i < n; i++) begin
      while (!rd_valid_o) tick();
      exp_rd_data = model[addr + i];
      rd_pop_i = 1'b1;
      tick();
      rd_pop_i = 1'b0;
    end
  endtask

  // Debug read burst with the host popping alongside
  task automatic dbg_read(int addr, int words);
    int good;
    good = (addr + words > MEM_WORDS) ? MEM_WORDS - addr : words;
    fork
      dbg_command(addr, words, 1'b0, '0);
      pop_words(addr, good);
    join
    expect_empty = 1'b1;
    tick();
    expect_empty = 1'b0;
  endtask

  initial begin
    #(N_PLANNED * 40 * PERIOD);
    $display("Timeout: the run did not finish, %0d mismatches so far", mismatches);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    word_addr_t a;
    data_t      d;
    rst_n_i        = 1'b0;
    cpu_req_i      = 1'b0;
    cpu_bus_i      = '0;
    dbg_cmd_req_i  = 1'b0;
    dbg_cmd_i      = '0;
    rd_pop_i       = 1'b0;
    lfsr           = 32'he6d7;
    known          = '0;
    mismatches     = 0;
    exp_cpu_rdata  = '0;
    exp_cpu_err    = 1'b0;
    chk_cpu_rdata  = 1'b0;
    exp_dbg_err    = 1'b0;
    exp_rd_data    = '0;
    expect_empty   = 1'b0;
    dbg_pending    = 1'b0;
    cpu_seq_active = 1'b0;
    stall_check    = 1'b0;
    drain_check    = 1'b0;
    repeat (4) @(posedge apb4_in_clk_i);
    #2 rst_n_i = 1'b1;
    tick();
    // CPU write then read, then random pairs
    cpu_access(5, 1'b1, 32'h1234_5678);
    cpu_access(5, 1'b0, '0);
    for (int i = 0; i < 30; i++) begin
      a = word_addr_t'(take_bits(8));
      d = take_bits(32);
      cpu_access(a, 1'b1, d);
      written_q.push_back(a);
      cpu_access(written_q[take_bits(4) % written_q.size()], 1'b0, '0);
    end
    // Debug fill, CPU readback, debug readback
    dbg_command(16, 8, 1'b1, 32'hcafe_0016);
    for (int i = 16; i < 24; i++) cpu_access(i, 1'b0, '0);
    dbg_read(16, 8);
    // Range errors from CPU and from crossing bursts
    cpu_access(0, 1'b1, 32'h0000_a11a);
    cpu_access(MEM_WORDS, 1'b1, 32'hdead_beef);
    cpu_access(MEM_WORDS + 3, 1'b0, '0);
    dbg_command(252, 7, 1'b1, 32'h0bad_0252);
    dbg_read(254, 4);
    // Word 0 shares its index with the first address past the end
    cpu_access(0, 1'b0, '0);
    // Both locks rise together from idle, debug fill lands before the CPU read
    for (int i = 40; i < 44; i++) begin
      model[i] = 32'h4040_4040;
      known[i] = 1'b1;
    end
    dbg_pending = 1'b1;
    fork
      dbg_command(40, 4, 1'b1, 32'h4040_4040);
      begin
        tick();
        cpu_access(41, 1'b0, '0);
      end
    join
    // CPU already owns the bus when the debug read arrives
    cpu_lock(1'b1);
    cpu_seq_active = 1'b1;
    fork
      begin
        for (int i = 100; i < 103; i++) cpu_xfer(i, 1'b1, 32'h100 + i);
        cpu_seq_active = 1'b0;
        cpu_lock(1'b0);
      end
      begin
        tick();
        dbg_read(16, 8);
      end
    join
    // Distinct words so that order, loss and repeats show in the FIFO data
    for (int i = 32; i < 48; i++) begin
      d = take_bits(32);
      cpu_access(i, 1'b1, d);
    end
    // Full FIFO stalls a 16-word read until the host pops
    fork
      dbg_command(32, 16, 1'b0, '0);
      begin
        while (!rd_valid_o) tick();
        // Longer than the whole burst would take without stalling
        repeat (100) tick();
        stall_check = 1'b1;
        tick();
        stall_check = 1'b0;
        drain_check = 1'b1;
        pop_words(32, 16);
        drain_check = 1'b0;
      end
    join
    expect_empty = 1'b1;
    tick();
    expect_empty = 1'b0;
    $display("Result: %0d mismatches", mismatches);
    if (mismatches == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/mam_pkg.sv
source/mam_cmd_engine.sv
source/mam_bus_arbiter.sv
source/mam_rdata_fifo.sv
source/mam_sram_target.sv
source/mam_subsystem_top.sv
dv/mam_subsystem_properties.sv
dv/mam_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory access subsystem testbench

VERILATOR ?= verilator
TOP       ?= mam_subsystem_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
